/* Makefile */
TOP := tb_layers

.PHONY: help test clean

help:
	@echo "help   list the targets"
	@echo "test   build $(TOP) with Verilator and run it"
	@echo "clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* activation.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module activation (
    input  logic                clk,
    input  layer_pkg::num_t     pooled,
    input  layer_pkg::ker_t     bias,
    layer_ctrl_if.lane          lane,
    output layer_pkg::pix_t     pixel
);
    import layer_pkg::*;

    localparam num_t pix_max = (2 ** (`LAYER_IMG_WIDTH - 1)) - 1;
    localparam num_t pix_min = -(2 ** (`LAYER_IMG_WIDTH - 1));

    ker_t   bias_q;
    num_t   biased;
    num_t   rectified;
    num_t   shifted;

    // held from the last handover while the next frame accumulates
    always_ff @(posedge clk) begin
        if (lane.sum_load) begin
            bias_q <= bias;
        end
    end

    always_ff @(posedge clk) begin
        biased <= pooled + num_t'(bias_q);
    end

    always_ff @(posedge clk) begin
        rectified <= (!lane.bypass && (biased < 0)) ? '0 : biased;
    end

    assign shifted = rectified >>> lane.shift;

    // clamp to the signed pixel range
    always_ff @(posedge clk) begin
        if (shifted > pix_max) begin
            pixel <= pix_max[`LAYER_IMG_WIDTH-1:0];
        end else if (shifted < pix_min) begin
            pixel <= pix_min[`LAYER_IMG_WIDTH-1:0];
        end else begin
            pixel <= shifted[`LAYER_IMG_WIDTH-1:0];
        end
    end

endmodule

/* layer_ctrl.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module layer_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [`LAYER_CFG_DWIDTH-1:0]    cfg_data,
    input  logic [`LAYER_CFG_AWIDTH-1:0]    cfg_addr,
    input  logic                            cfg_valid,
    input  logic                            image_val,
    input  logic                            image_last,
    input  logic                            result_rdy,
    output logic                            image_rdy,
    output logic                            kernel_rdy,
    output logic                            result_val,
    output logic                            out_load,
    layer_ctrl_if.ctrl                      ctrl
);
    import layer_pkg::*;

    up_state_t                      up_state;
    up_state_t                      up_state_nx;
    dn_state_t                      dn_state;
    dn_state_t                      dn_state_nx;
    logic [`LAYER_CFG_FIELD_W-1:0]  pool_nb;
    logic [`LAYER_CFG_FIELD_W-1:0]  pool_cnt;
    logic                           image_xfer;
    logic                           handover;
    logic                           pool_done;
    logic                           last_1p;
    logic                           mac_dly_1p;
    logic                           mac_dly_2p;
    logic                           mac_done;
    logic                           add_valid;
    logic                           ops_dly_1p;
    logic                           ops_dly_2p;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.bypass <= 1'b0;
            pool_nb     <= '0;
            ctrl.shift  <= '0;
        end else if (cfg_valid && (cfg_addr == `LAYER_CFG_ADDR)) begin
            ctrl.bypass <= cfg_data[`LAYER_CFG_BYPASS_BIT];
            pool_nb     <= cfg_data[`LAYER_CFG_POOL_LSB +: `LAYER_CFG_FIELD_W];
            ctrl.shift  <= cfg_data[`LAYER_CFG_SHIFT_LSB +: `LAYER_CFG_FIELD_W];
        end
    end

    assign image_xfer = image_val && image_rdy;
    assign handover   = (up_state == UP_CLEAR) && (dn_state == DN_READY);
    assign pool_done  = (dn_state == DN_POOL) && (pool_cnt >= pool_nb);

    // kernel request and the mac latency chain behind the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            last_1p    <= 1'b0;
            mac_dly_1p <= 1'b0;
            mac_dly_2p <= 1'b0;
            mac_done   <= 1'b0;
        end else begin
            kernel_rdy <= image_xfer;
            last_1p    <= image_xfer && image_last;
            mac_dly_1p <= last_1p;
            mac_dly_2p <= mac_dly_1p;
            mac_done   <= mac_dly_2p;
        end
    end

    // sum, then pool, then three activation stages before the result load
    always_ff @(posedge clk) begin
        if (rst) begin
            add_valid  <= 1'b0;
            ops_dly_1p <= 1'b0;
            ops_dly_2p <= 1'b0;
            out_load   <= 1'b0;
        end else begin
            add_valid  <= handover;
            ops_dly_1p <= pool_done;
            ops_dly_2p <= ops_dly_1p;
            out_load   <= ops_dly_2p;
        end
    end

    // frames pooled so far in the current window
    always_ff @(posedge clk) begin
        if (rst || (dn_state == DN_RESET)) begin
            pool_cnt <= '0;
        end else if (dn_state == DN_POOL) begin
            pool_cnt <= pool_done ? '0 : pool_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= UP_RESET;
            dn_state <= DN_RESET;
        end else begin
            up_state <= up_state_nx;
            dn_state <= dn_state_nx;
        end
    end

    always_comb begin
        up_state_nx = up_state;
        case (up_state)
            UP_RESET: up_state_nx = UP_READY;
            UP_READY: if (image_val && image_last) up_state_nx = UP_DONE;
            UP_DONE:  if (mac_done) up_state_nx = UP_CLEAR;
            UP_CLEAR: if (dn_state == DN_READY) up_state_nx = UP_RESET;
            default:  up_state_nx = UP_RESET;
        endcase
    end

    always_comb begin
        dn_state_nx = dn_state;
        case (dn_state)
            DN_RESET: dn_state_nx = DN_READY;
            DN_READY: if (up_state == UP_CLEAR) dn_state_nx = DN_ADD;
            DN_ADD:   if (add_valid) dn_state_nx = DN_POOL;
            DN_POOL:  dn_state_nx = pool_done ? DN_OPS : DN_READY;
            DN_OPS:   if (out_load) dn_state_nx = DN_CLEAR;
            DN_CLEAR: if (result_rdy) dn_state_nx = DN_RESET;
            default:  dn_state_nx = DN_RESET;
        endcase
    end

    assign image_rdy       = (up_state == UP_READY);
    assign result_val      = (dn_state == DN_CLEAR);

    assign ctrl.mac_clear  = (up_state == UP_RESET);
    assign ctrl.mac_en     = kernel_rdy;
    assign ctrl.sum_load   = handover;
    assign ctrl.pool_en    = add_valid;
    assign ctrl.pool_first = (pool_cnt == '0);

endmodule

/* layer_ctrl_if.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

interface layer_ctrl_if;

    logic                           mac_clear;
    logic                           mac_en;
    logic                           sum_load;
    logic                           pool_first;
    logic                           pool_en;
    logic                           bypass;
    logic [`LAYER_CFG_FIELD_W-1:0]  shift;

    modport ctrl (
        output mac_clear, mac_en, sum_load, pool_first, pool_en, bypass, shift
    );

    modport lane (
        input  mac_clear, mac_en, sum_load, pool_first, pool_en, bypass, shift
    );

endinterface

/* layer_defs.svh */
`ifndef LAYER_DEFS_SVH
`define LAYER_DEFS_SVH

// output channels and pixels per image beat
`define LAYER_DEPTH_NB          4
`define LAYER_GROUP_NB          4

// signed data widths
`define LAYER_IMG_WIDTH         16
`define LAYER_KER_WIDTH         16
`define LAYER_NUM_WIDTH         (`LAYER_IMG_WIDTH + `LAYER_KER_WIDTH + 1)

// cfg bus
`define LAYER_CFG_DWIDTH        32
`define LAYER_CFG_AWIDTH        5
`define LAYER_CFG_ADDR          2

// pool and shift fields of the layer register are one byte each
`define LAYER_CFG_BYPASS_BIT    16
`define LAYER_CFG_POOL_LSB      8
`define LAYER_CFG_SHIFT_LSB     0
`define LAYER_CFG_FIELD_W       8

`endif

/* layer_pkg.sv */
package layer_pkg;

`include "layer_defs.svh"

    // accumulator word, wide enough for one full product plus sign
    typedef logic signed [`LAYER_NUM_WIDTH-1:0] num_t;

    typedef logic signed [`LAYER_IMG_WIDTH-1:0] pix_t;
    typedef logic signed [`LAYER_KER_WIDTH-1:0] ker_t;

    // accumulation side
    typedef enum logic [1:0] {
        UP_RESET,
        UP_READY,
        UP_DONE,
        UP_CLEAR
    } up_state_t;

    // post-operation side
    typedef enum logic [2:0] {
        DN_RESET,
        DN_READY,
        DN_ADD,
        DN_POOL,
        DN_OPS,
        DN_CLEAR
    } dn_state_t;

endpackage

/* layers.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module layers (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [`LAYER_CFG_DWIDTH-1:0]                            cfg_data,
    input  logic [`LAYER_CFG_AWIDTH-1:0]                            cfg_addr,
    input  logic                                                    cfg_valid,
    input  logic [`LAYER_DEPTH_NB*`LAYER_KER_WIDTH-1:0]             bias_bus,
    input  logic [`LAYER_DEPTH_NB*`LAYER_GROUP_NB*`LAYER_KER_WIDTH-1:0] kernel_bus,
    output logic                                                    kernel_rdy,
    input  logic [`LAYER_GROUP_NB*`LAYER_IMG_WIDTH-1:0]             image_bus,
    input  logic                                                    image_last,
    input  logic                                                    image_val,
    output logic                                                    image_rdy,
    output logic [`LAYER_DEPTH_NB*`LAYER_IMG_WIDTH-1:0]             result_bus,
    output logic                                                    result_val,
    input  logic                                                    result_rdy
);
    import layer_pkg::*;

    localparam int ker_slice = `LAYER_GROUP_NB * `LAYER_KER_WIDTH;

    layer_ctrl_if                   ctrl_if ();
    logic                           out_load;
    pix_t [`LAYER_GROUP_NB-1:0]     image_1p;
    ker_t [`LAYER_DEPTH_NB-1:0]     bias_1p;
    pix_t [`LAYER_DEPTH_NB-1:0]     pixel;

    layer_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .image_val  (image_val),
        .image_last (image_last),
        .result_rdy (result_rdy),
        .image_rdy  (image_rdy),
        .kernel_rdy (kernel_rdy),
        .result_val (result_val),
        .out_load   (out_load),
        .ctrl       (ctrl_if.ctrl)
    );

    // beat is consumed by the lanes on the following kernel_rdy cycle
    always_ff @(posedge clk) begin
        if (image_val && image_rdy) begin
            image_1p <= image_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (kernel_rdy) begin
            bias_1p <= bias_bus;
        end
    end

    // held while result_val waits for result_rdy
    always_ff @(posedge clk) begin
        if (out_load) begin
            result_bus <= pixel;
        end
    end

    for (genvar i = 0; i < `LAYER_DEPTH_NB; i++) begin : g_lane
        num_t [`LAYER_GROUP_NB-1:0] acc;
        num_t                       pooled;

        mac_group u_mac (
            .clk     (clk),
            .pixels  (image_1p),
            .kernels (kernel_bus[i*ker_slice +: ker_slice]),
            .lane    (ctrl_if.lane),
            .acc     (acc)
        );

        sum_pool u_pool (
            .clk    (clk),
            .acc    (acc),
            .lane   (ctrl_if.lane),
            .pooled (pooled)
        );

        activation u_act (
            .clk    (clk),
            .pooled (pooled),
            .bias   (bias_1p[i]),
            .lane   (ctrl_if.lane),
            .pixel  (pixel[i])
        );
    end

endmodule

/* layers_testdata.txt */
# c <cfg word hex>  b <last> <4 pixels> <4 kernels per channel, ch0..ch3> <4 bias>  e <4 results>
# decimal values are signed; cfg bit 16 bypass, bits 15:8 pool_nb, bits 7:0 shift
c 00000000
b 1  1 2 3 4  1 1 1 1  2 0 0 1  0 -1 2 0  1 -1 1 -1  5 -3 0 10
e 15 3 4 8
c 00000200
b 0  1 1 1 1  1 1 1 1  5 5 5 5  -1 -1 -1 -1  0 0 0 0  1 2 3 4
b 1  2 2 2 2  1 0 0 0  1 1 1 1  1 0 0 0  0 0 0 1  1 2 3 4
b 0  1 2 3 4  1 1 1 1  1 0 0 0  0 0 0 -1  1 1 1 1  1 2 3 4
b 1  1 1 1 1  1 1 1 1  0 0 0 0  0 0 0 0  1 1 1 1  1 2 3 4
b 0  3 3 3 3  0 0 0 0  1 1 1 1  -1 0 0 0  2 2 2 2  1 2 3 4
b 1  -1 -1 -1 -1  1 1 1 1  1 1 1 1  1 1 1 1  1 0 0 0  1 2 3 4
e 15 30 1 27
c 00000000
b 1  1 2 3 4  -1 -1 -1 -1  1 1 1 1  0 0 0 -5  0 0 0 0  0 0 0 -1
e 0 10 0 0
c 00010000
b 1  1 2 3 4  -1 -1 -1 -1  1 1 1 1  0 0 0 -5  0 0 0 0  0 0 0 -1
e -10 10 -20 -1
c 00010004
b 1  1000 2000 3000 4000  10 10 10 10  100 100 100 100  -100 -100 -100 -100  -3 0 0 0  3 0 0 -5
e 6250 32767 -32768 -188
c 00000001
b 1  2 4 6 8  1 1 1 1  1 0 0 0  0 1 0 0  -1 -1 -1 -1  1 1 1 1
e 10 1 2 0
b 1  10 10 10 10  1 1 1 1  2 2 2 2  -1 0 0 0  0 0 0 3  0 0 0 0
e 20 40 0 15
b 1  -2 -2 -2 -2  -1 -1 -1 -1  1 1 1 1  5 5 5 5  -3 -3 -3 -3  1 1 1 1
e 4 0 0 12

/* list.f */
+incdir+.
layer_pkg.sv
layer_ctrl_if.sv
layer_ctrl.sv
mac_group.sv
sum_pool.sv
activation.sv
layers.sv
tb_layers.sv

/* mac_group.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module mac_group (
    input  logic                                    clk,
    input  layer_pkg::pix_t [`LAYER_GROUP_NB-1:0]   pixels,
    input  layer_pkg::ker_t [`LAYER_GROUP_NB-1:0]   kernels,
    layer_ctrl_if.lane                              lane,
    output layer_pkg::num_t [`LAYER_GROUP_NB-1:0]   acc
);
    import layer_pkg::*;

    num_t [`LAYER_GROUP_NB-1:0] prod;
    logic                       add_en;

    // product register stage
    always_ff @(posedge clk) begin
        if (lane.mac_en) begin
            for (int i = 0; i < `LAYER_GROUP_NB; i++) begin
                prod[i] <= pixels[i] * kernels[i];
            end
        end
    end

    // add follows the product by one cycle
    always_ff @(posedge clk) begin
        if (lane.mac_clear) begin
            add_en <= 1'b0;
        end else begin
            add_en <= lane.mac_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LAYER_GROUP_NB; i++) begin
            if (lane.mac_clear) begin
                acc[i] <= '0;
            end else if (add_en) begin
                acc[i] <= acc[i] + prod[i];
            end
        end
    end

endmodule

/* sum_pool.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module sum_pool (
    input  logic                                    clk,
    input  layer_pkg::num_t [`LAYER_GROUP_NB-1:0]   acc,
    layer_ctrl_if.lane                              lane,
    output layer_pkg::num_t                         pooled
);
    import layer_pkg::*;

    num_t   sum_nx;
    num_t   sum;

    // adder tree over the group lanes
    always_comb begin
        sum_nx = '0;
        for (int i = 0; i < `LAYER_GROUP_NB; i++) begin
            sum_nx = sum_nx + acc[i];
        end
    end

    // accumulators are cleared right after the handover, so latch them here
    always_ff @(posedge clk) begin
        if (lane.sum_load) begin
            sum <= sum_nx;
        end
    end

    // first frame of a window restarts the running maximum
    always_ff @(posedge clk) begin
        if (lane.pool_en) begin
            if (lane.pool_first || (sum > pooled)) begin
                pooled <= sum;
            end
        end
    end

endmodule

/* tb_layers.sv */
`timescale 1ns/10ps

`include "layer_defs.svh"

module tb_layers;
    import layer_pkg::*;

    localparam int depth_nb = `LAYER_DEPTH_NB;
    localparam int group_nb = `LAYER_GROUP_NB;
    localparam int iw = `LAYER_IMG_WIDTH;
    localparam int kw = `LAYER_KER_WIDTH;
    localparam int timeout_cycles = 1000;

    logic                               clk;
    logic                               rst;
    logic [`LAYER_CFG_DWIDTH-1:0]       cfg_data;
    logic [`LAYER_CFG_AWIDTH-1:0]       cfg_addr;
    logic                               cfg_valid;
    logic [depth_nb*kw-1:0]             bias_bus;
    logic [depth_nb*group_nb*kw-1:0]    kernel_bus;
    logic                               kernel_rdy;
    logic [group_nb*iw-1:0]             image_bus;
    logic                               image_last;
    logic                               image_val;
    logic                               image_rdy;
    logic [depth_nb*iw-1:0]             result_bus;
    logic                               result_val;
    logic                               result_rdy;

    // one packed word per expected result, oldest first
    logic [depth_nb*iw-1:0]             exp_q[$];

    layers u_layers (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .bias_bus   (bias_bus),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input string name, input pix_t exp, input pix_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR at %0t ns: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic read_num(input int fd, output int v);
        int rc;
        rc = $fscanf(fd, "%d", v);
        if (rc != 1) begin
            abort_run("layers_testdata.txt has a malformed line");
        end
    endtask

    // waits until every queued result has been taken from the DUT
    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (++n > timeout_cycles) begin
                abort_run($sformatf("timeout waiting for the results before %s", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic write_cfg(input logic [31:0] word);
        @(posedge clk);
        #1;
        cfg_addr  = `LAYER_CFG_ADDR;
        cfg_data  = word;
        cfg_valid = 1'b1;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
    endtask

    // kernel and bias stay on the bus through the kernel_rdy cycle
    task automatic drive_beat(input logic last, input logic [group_nb*iw-1:0] img,
                              input logic [depth_nb*group_nb*kw-1:0] ker,
                              input logic [depth_nb*kw-1:0] bias);
        int n;
        @(posedge clk);
        #1;
        image_bus  = img;
        kernel_bus = ker;
        bias_bus   = bias;
        image_last = last;
        image_val  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!image_rdy) begin
            if (++n > timeout_cycles) abort_run("timeout waiting for image_rdy");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        image_val  = 1'b0;
        image_last = 1'b0;
        n = 0;
        @(negedge clk);
        while (!kernel_rdy) begin
            if (++n > timeout_cycles) abort_run("timeout waiting for kernel_rdy");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin : backpressure
        logic [31:0] lfsr;
        lfsr = 32'hc761ec6a;
        result_rdy = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            lfsr = lfsr_step(lfsr);
            result_rdy = lfsr[0];
        end
    end

    // result_bus must hold while the DUT waits for result_rdy
    initial begin : monitor
        logic [depth_nb*iw-1:0] held;
        logic [depth_nb*iw-1:0] exp;
        logic                   holding;
        holding = 1'b0;
        forever begin
            @(negedge clk);
            if (result_val === 1'b1) begin
                for (int i = 0; i < depth_nb && holding; i++) begin
                    check_pixel($sformatf("result_bus[%0d] hold", i), held[i*iw +: iw],
                                result_bus[i*iw +: iw]);
                end
                if (result_rdy) begin
                    if (exp_q.size() == 0) abort_run("result_val high with no result expected");
                    exp = exp_q.pop_front();
                    for (int i = 0; i < depth_nb; i++) begin
                        check_pixel($sformatf("result_bus[%0d]", i), exp[i*iw +: iw],
                                    result_bus[i*iw +: iw]);
                    end
                    holding = 1'b0;
                end else begin
                    held    = result_bus;
                    holding = 1'b1;
                end
            end
        end
    end

    initial begin : driver
        int                             fd;
        int                             c;
        int                             v;
        int                             last;
        int                             n;
        logic [31:0]                    word;
        logic [group_nb*iw-1:0]         img;
        logic [depth_nb*group_nb*kw-1:0] ker;
        logic [depth_nb*kw-1:0]         bias;
        logic [depth_nb*iw-1:0]         exp;
        rst        = 1'b1;
        cfg_data   = '0;
        cfg_addr   = '0;
        cfg_valid  = 1'b0;
        bias_bus   = '0;
        kernel_bus = '0;
        image_bus  = '0;
        image_last = 1'b0;
        image_val  = 1'b0;
        fd = $fopen("layers_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open layers_testdata.txt");
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_level("image_rdy", 1'b0, image_rdy);
        check_level("kernel_rdy", 1'b0, kernel_rdy);
        check_level("result_val", 1'b0, result_val);
        n = 0;
        while (!image_rdy) begin
            if (++n > timeout_cycles) abort_run("image_rdy never rose after reset");
            @(negedge clk);
        end
        c = $fgetc(fd);
        while (c != -1) begin
            case (c)
                "#": while (c != "\n" && c != -1) c = $fgetc(fd);
                "c": begin
                    if ($fscanf(fd, "%h", word) != 1) abort_run("bad cfg word in data file");
                    wait_drain("a cfg write");
                    write_cfg(word);
                end
                "b": begin
                    read_num(fd, last);
                    for (int g = 0; g < group_nb; g++) begin
                        read_num(fd, v);
                        img[g*iw +: iw] = v[iw-1:0];
                    end
                    for (int k = 0; k < depth_nb * group_nb; k++) begin
                        read_num(fd, v);
                        ker[k*kw +: kw] = v[kw-1:0];
                    end
                    for (int d = 0; d < depth_nb; d++) begin
                        read_num(fd, v);
                        bias[d*kw +: kw] = v[kw-1:0];
                    end
                    drive_beat(last[0], img, ker, bias);
                end
                "e": begin
                    for (int d = 0; d < depth_nb; d++) begin
                        read_num(fd, v);
                        exp[d*iw +: iw] = v[iw-1:0];
                    end
                    exp_q.push_back(exp);
                end
                default: ;
            endcase
            c = $fgetc(fd);
        end
        $fclose(fd);
        wait_drain("the end of the run");
        $display("NO ERRORS");
        $finish;
    end

endmodule
